// File: color_conv.sv
`default_nettype none

module color_conv import ppu_pkg::*; (
  input  wire logic VCLK_Tx,
  input  wire logic nVRST_Tx,
  input  wire logic en_ypbpr_i,
  vdata_if.snk      vin,
  vdata_if.src      vout
);

  // Products and sums fit signed 18 bits
  localparam int SUM_W = 18;

  // Rows y, pb, pr; columns r, g, b; scaled by 256
  localparam logic signed [SUM_W-1:0] COEF [9] = '{
    18'sd77,  18'sd150,  18'sd29,
    -18'sd43, -18'sd85,  18'sd128,
    18'sd128, -18'sd107, -18'sd21
  };
  // Mid-scale offset for the colour difference channels
  localparam logic signed [SUM_W-1:0] OFFSET = 18'sd128;

  logic [COLOR_W-1:0]      ch [3];
  logic signed [SUM_W-1:0] prod [9];
  logic signed [SUM_W-1:0] acc [3];
  logic [COLOR_W-1:0]      res [3];
  pixel_t                  yuv_pix;

  // Stage 1 companions of the products
  logic                    valid_q;
  logic [3:0]              sync_q;
  pixel_t                  pix_q;
  logic                    en_q;

  function automatic logic [COLOR_W-1:0] clamp8(input logic signed [SUM_W-1:0] v);
    if (v[SUM_W-1])
      return '0;
    else if (v > 18'sd255)
      return '1;
    return v[COLOR_W-1:0];
  endfunction

  assign ch[0] = vin.pix.rgb.r;
  assign ch[1] = vin.pix.rgb.g;
  assign ch[2] = vin.pix.rgb.b;

  // --------------------------------------------------------------------------
  // Stage 1, nine products
  // --------------------------------------------------------------------------

  always_ff @(posedge VCLK_Tx) begin
    for (int k = 0; k < 9; k++)
      prod[k] <= COEF[k] * $signed({{(SUM_W-COLOR_W){1'b0}}, ch[k % 3]});
    sync_q <= vin.sync;
    pix_q  <= vin.pix;
  end

  // Enable travels with the data so a change never splits a pixel
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      valid_q <= 1'b0;
      en_q    <= 1'b0;
    end else begin
      valid_q <= vin.valid;
      en_q    <= en_ypbpr_i;
    end
  end

  // --------------------------------------------------------------------------
  // Stage 2, sum, scale, offset and clamp
  // --------------------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      // Arithmetic shift floors negative sums
      acc[i] = (prod[3*i] + prod[3*i+1] + prod[3*i+2]) >>> 8;
      if (i != 0)
        acc[i] = acc[i] + OFFSET;
      res[i] = clamp8(acc[i]);
    end
    yuv_pix.ypbpr.y  = res[0];
    yuv_pix.ypbpr.pb = res[1];
    yuv_pix.ypbpr.pr = res[2];
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx)
      vout.valid <= 1'b0;
    else
      vout.valid <= valid_q;
  end

  // RGB bypass takes the same two registers
  always_ff @(posedge VCLK_Tx) begin
    vout.sync <= sync_q;
    vout.pix  <= en_q ? yuv_pix : pix_q;
  end

endmodule

`default_nettype wire

// File: ppu_cfg_regs.sv
`default_nettype none

module ppu_cfg_regs import ppu_pkg::*; (
  input  wire logic               VCLK_Tx,
  input  wire logic               nVRST_Tx,
  input  wire logic [CFG_W-1:0]   config_i,
  output logic                    testpat_o,
  output logic                    xchg_rb_o,
  output logic                    en_ypbpr_o,
  output logic                    en_rgsb_o,
  output logic                    videblur_o,
  output logic [1:0]              linemult_o,
  output logic [1:0]              filter_o,
  output logic [STATE_W-1:0]      ppu_state_o
);

  // Raw fields of the incoming word
  logic [1:0] lm_cfg;
  logic       pal_cfg;
  logic       n480i_cfg;

  // Legalized line multiplier for the next cycle
  logic [1:0] lm_next;

  // Registered mode info and filter field
  logic       palmode_q;
  logic       n480i_q;
  logic [1:0] filter_q;
  logic       filter_auto;

  assign lm_cfg    = config_i[CFG_LINEMULT +: 2];
  assign pal_cfg   = config_i[CFG_PALMODE];
  assign n480i_cfg = config_i[CFG_N480I];

  // --------------------------------------------------------------------------
  // Line multiplier rules
  // --------------------------------------------------------------------------

  always_comb begin
    if (n480i_cfg) begin
      // 480i only knows bypass or LineX2
      lm_next = {1'b0, lm_cfg[0]};
    end else if (pal_cfg || !config_i[CFG_USE_VPLL]) begin
      // No LineX3 in PAL or without the video PLL, fold 10 onto 01
      lm_next = {1'b0, ^lm_cfg};
    end else begin
      lm_next = lm_cfg;
    end
    // Test pattern always runs unmultiplied
    if (config_i[CFG_TESTPAT])
      lm_next = 2'b00;
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      testpat_o  <= 1'b0;
      xchg_rb_o  <= 1'b0;
      en_ypbpr_o <= 1'b0;
      en_rgsb_o  <= 1'b0;
      videblur_o <= 1'b0;
      linemult_o <= 2'b00;
      filter_q   <= 2'b00;
      palmode_q  <= 1'b0;
      n480i_q    <= 1'b0;
    end else begin
      testpat_o  <= config_i[CFG_TESTPAT];
      xchg_rb_o  <= config_i[CFG_XCHG_RB];
      en_ypbpr_o <= config_i[CFG_EN_YPBPR];
      en_rgsb_o  <= config_i[CFG_EN_RGSB];
      // Blur makes no sense on interlaced content
      videblur_o <= config_i[CFG_VIDEBLUR] & ~n480i_cfg;
      linemult_o <= lm_next;
      filter_q   <= config_i[CFG_FILTER +: 2];
      palmode_q  <= pal_cfg;
      n480i_q    <= n480i_cfg;
    end
  end

  // --------------------------------------------------------------------------
  // Filter select and state word
  // --------------------------------------------------------------------------

  // Auto picks the filter from the multiplier, manual codes step down by one
  assign filter_auto = (filter_q == 2'b00);
  assign filter_o    = filter_auto ? linemult_o : filter_q - 2'd1;

  assign ppu_state_o = {palmode_q, n480i_q, linemult_o, en_ypbpr_o, en_rgsb_o,
                        videblur_o, filter_o, filter_auto};

endmodule

`default_nettype wire

// File: ppu_out_top.sv
`default_nettype none

module ppu_out_top import ppu_pkg::*; (
  input  wire logic               VCLK_Tx,
  input  wire logic               nVRST_Tx,
  input  wire logic               vdata_valid_i,
  input  wire logic [3:0]         vsync_i,
  input  wire logic [PIX_W-1:0]   vcolor_i,
  input  wire logic [CFG_W-1:0]   config_i,
  input  wire logic               use_vga_i,
  output logic [PIX_W-1:0]        vd_o,
  output logic [1:0]              ncsync_o,
  output logic                    nvsync_or_f2_o,
  output logic                    nhsync_or_f1_o,
  output logic [STATE_W-1:0]      ppu_state_o
);

  // Registered settings
  logic       testpat;
  logic       xchg_rb;
  logic       en_ypbpr;
  logic       en_rgsb;
  logic       videblur;
  logic [1:0] linemult;
  logic [1:0] filter;

  // Input, pattern to encoder, encoder to output
  vdata_if in_if ();
  vdata_if tp_if ();
  vdata_if cc_if ();

  assign in_if.valid = vdata_valid_i;
  assign in_if.sync  = vsync_i;
  assign in_if.pix   = vcolor_i;

  // --------------------------------------------------------------------------
  // Settings and pipeline
  // --------------------------------------------------------------------------

  ppu_cfg_regs cfg_regs_u (
    .VCLK_Tx(VCLK_Tx), .nVRST_Tx(nVRST_Tx), .config_i(config_i),
    .testpat_o(testpat), .xchg_rb_o(xchg_rb), .en_ypbpr_o(en_ypbpr),
    .en_rgsb_o(en_rgsb), .videblur_o(videblur), .linemult_o(linemult),
    .filter_o(filter), .ppu_state_o(ppu_state_o)
  );

  testpat_gen testpat_u (
    .VCLK_Tx(VCLK_Tx), .nVRST_Tx(nVRST_Tx), .testpat_i(testpat),
    .vin(in_if.snk), .vout(tp_if.src)
  );

  color_conv conv_u (
    .VCLK_Tx(VCLK_Tx), .nVRST_Tx(nVRST_Tx), .en_ypbpr_i(en_ypbpr),
    .vin(tp_if.snk), .vout(cc_if.src)
  );

  vout_stage vout_u (
    .VCLK_Tx(VCLK_Tx), .nVRST_Tx(nVRST_Tx), .vin(cc_if.snk),
    .xchg_rb_i(xchg_rb), .en_ypbpr_i(en_ypbpr), .en_rgsb_i(en_rgsb),
    .videblur_i(videblur), .testpat_i(testpat), .linemult_i(linemult),
    .filter_i(filter), .use_vga_i(use_vga_i), .vd_o(vd_o), .ncsync_o(ncsync_o),
    .nvsync_or_f2_o(nvsync_or_f2_o), .nhsync_or_f1_o(nhsync_or_f1_o)
  );

endmodule

`default_nettype wire

// File: ppu_pkg.sv
`default_nettype none

package ppu_pkg;

  // --------------------------------------------------------------------------
  // Pixel word
  // --------------------------------------------------------------------------

  // Bits per colour channel
  localparam int COLOR_W = 8;
  // Three channels in one word
  localparam int PIX_W = 3 * COLOR_W;

  // One pixel word, read as RGB ahead of the encoder and as YPbPr behind it
  // First channel sits in the top byte in both views
  typedef union packed {
    struct packed {
      logic [COLOR_W-1:0] r;
      logic [COLOR_W-1:0] g;
      logic [COLOR_W-1:0] b;
    } rgb;
    struct packed {
      logic [COLOR_W-1:0] y;
      logic [COLOR_W-1:0] pb;
      logic [COLOR_W-1:0] pr;
    } ypbpr;
  } pixel_t;

  // --------------------------------------------------------------------------
  // Configuration word
  // --------------------------------------------------------------------------

  localparam int CFG_W = 16;

  localparam int CFG_TESTPAT   = 0;
  localparam int CFG_XCHG_RB   = 1;
  // LSB of the 2-bit filter field: 00 auto, 01 9.5MHz, 10 18MHz, 11 bypass
  localparam int CFG_FILTER    = 2;
  localparam int CFG_EN_YPBPR  = 4;
  localparam int CFG_EN_RGSB   = 5;
  localparam int CFG_VIDEBLUR  = 6;
  // LSB of the 2-bit line multiplier field
  localparam int CFG_LINEMULT  = 7;
  localparam int CFG_PALMODE   = 9;
  localparam int CFG_N480I     = 10;
  localparam int CFG_USE_VPLL  = 11;
  // Bits 15:12 reserved

  // --------------------------------------------------------------------------
  // Sync nibble, all active low
  // --------------------------------------------------------------------------

  localparam int SY_NVSYNC = 3;
  localparam int SY_NBLANK = 2;
  localparam int SY_NHSYNC = 1;
  localparam int SY_NCSYNC = 0;

  // Packed status word towards the controller
  localparam int STATE_W = 10;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the output pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tb_ppu_out -o tb_ppu_out
./obj_dir/tb_ppu_out +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
if grep -q ">>> FAIL" sim.log; then
  exit 1
fi
grep -q ">>> PASS" sim.log

// File: src.f
ppu_pkg.sv
vdata_if.sv
ppu_cfg_regs.sv
testpat_gen.sv
color_conv.sv
vout_stage.sv
ppu_out_top.sv
tb_ppu_out_asserts.sv
tb_ppu_out.sv

// File: tb_ppu_out.sv
`default_nettype none

module tb_ppu_out import ppu_pkg::*; ();

  // Line format and run limit
  localparam int ACTIVE   = 256;
  localparam int HS_LEN   = 16;
  localparam int LINE_CYC = 300;
  localparam int LINES    = 12;
  localparam int LIMIT    = LINES * LINE_CYC + 800;

  // Pass-through, R/B swap, YPbPr twice, YPbPr with swap and RGsB, pattern,
  // blur at linemult 00/01/10/11, blur in 480i, RGsB with VGA pins
  localparam logic [CFG_W-1:0] LINE_CFG [LINES] = '{
    16'h0800, 16'h0802, 16'h0810, 16'h0810, 16'h0832, 16'h0941,
    16'h0840, 16'h08C0, 16'h0940, 16'h09C0, 16'h0CC0, 16'h0820
  };
  // PAL at 10, no PLL at 10, filter auto/01/10/11 at linemult 11
  localparam logic [CFG_W-1:0] REG_CFG [6] = '{
    16'h0B00, 16'h0100, 16'h0980, 16'h0984, 16'h0988, 16'h098C
  };

  logic               VCLK_Tx;
  logic               nVRST_Tx;
  logic               vdata_valid_i;
  logic [3:0]         vsync_i;
  logic [PIX_W-1:0]   vcolor_i;
  logic [CFG_W-1:0]   config_i;
  logic               use_vga_i;
  logic [PIX_W-1:0]   vd_o;
  logic [1:0]         ncsync_o;
  logic               nvsync_or_f2_o;
  logic               nhsync_or_f1_o;
  logic [STATE_W-1:0] ppu_state_o;

  int seed = 32'h45b9b784;
  int cyc = 0;
  int errors = 0;
  // Expected vd_o words and the cycle each one is due
  logic [PIX_W-1:0] exp_q [$];
  int               due_q [$];

  ppu_out_top UUT (.*);

  initial VCLK_Tx = 1'b0;
  always #5 VCLK_Tx = ~VCLK_Tx;

  always @(posedge VCLK_Tx) begin
    cyc <= cyc + 1;
    if (cyc > LIMIT) begin
      $display("timeout: test sequence still running after %0d cycles", cyc);
      $display(">>> FAIL");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------

  function automatic logic [7:0] clip(input int v);
    return (v < 0) ? 8'd0 : (v > 255) ? 8'd255 : v[7:0];
  endfunction

  // Matrix scaled by 256, arithmetic shift floors
  function automatic logic [PIX_W-1:0] to_ypbpr(input logic [PIX_W-1:0] p);
    int r;
    int g;
    int b;
    r = int'(p[23:16]);
    g = int'(p[15:8]);
    b = int'(p[7:0]);
    return {clip((77*r + 150*g + 29*b) >>> 8),
            clip(((-43*r - 85*g + 128*b) >>> 8) + 128),
            clip(((128*r - 107*g - 21*b) >>> 8) + 128)};
  endfunction

  // 480i and PAL or no PLL fold the multiplier, the pattern clears it
  function automatic logic [STATE_W-1:0] exp_state(input logic [CFG_W-1:0] cfg);
    logic [1:0] lm;
    logic [1:0] fld;
    lm  = cfg[CFG_LINEMULT +: 2];
    fld = cfg[CFG_FILTER +: 2];
    if (cfg[CFG_N480I])
      lm = {1'b0, lm[0]};
    else if (cfg[CFG_PALMODE] || !cfg[CFG_USE_VPLL])
      lm = {1'b0, lm[1] ^ lm[0]};
    if (cfg[CFG_TESTPAT])
      lm = 2'b00;
    // pal, 480i, lm, ypbpr, rgsb, blur, filter select, auto
    return {cfg[CFG_PALMODE], cfg[CFG_N480I], lm, cfg[CFG_EN_YPBPR], cfg[CFG_EN_RGSB],
            cfg[CFG_VIDEBLUR] & ~cfg[CFG_N480I], (fld == 2'b00) ? lm : fld - 2'd1,
            fld == 2'b00};
  endfunction

  function automatic logic [PIX_W-1:0] exp_pixel(input logic [CFG_W-1:0] cfg,
                                                 input int pos, input logic [PIX_W-1:0] rgb);
    logic [PIX_W-1:0] p;
    p = rgb;
    // Eight 32-pixel bars, index bits switch r, g, b fully on or off
    if (cfg[CFG_TESTPAT])
      p = {{8{pos[7]}}, {8{pos[6]}}, {8{pos[5]}}};
    if (cfg[CFG_EN_YPBPR])
      p = to_ypbpr(p);
    if (cfg[CFG_XCHG_RB])
      p = {p[7:0], p[15:8], p[23:16]};
    return p;
  endfunction

  // --------------------------------------------------------------------------
  // Stimulus and checks
  // --------------------------------------------------------------------------

  task automatic compare_hex(input string name, input logic [PIX_W-1:0] exp,
                             input logic [PIX_W-1:0] act);
    assert (act === exp) else begin
      errors++;
      $display("error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  // Falling edge, then every vd_o word due by now
  task automatic tick();
    @(negedge VCLK_Tx);
    while (due_q.size() > 0 && due_q[0] <= cyc) begin
      compare_hex("vd_o", exp_q.pop_front(), vd_o);
      void'(due_q.pop_front());
    end
  endtask

  task automatic set_config(input logic [CFG_W-1:0] cfg, input logic vga);
    logic [STATE_W-1:0] st;
    tick();
    config_i  = cfg;
    use_vga_i = vga;
    repeat (4) tick();
    st = exp_state(cfg);
    compare_hex("ppu_state_o", {14'h0, st}, {14'h0, ppu_state_o});
    // Filter select on the shared pins
    if (!vga)
      compare_hex("nvsync_or_f2_o/nhsync_or_f1_o", {22'h0, st[2:1]},
                  {22'h0, nvsync_or_f2_o, nhsync_or_f1_o});
  endtask

  task automatic run_line(input logic [CFG_W-1:0] cfg, input logic vs_low);
    logic [STATE_W-1:0] st;
    logic [PIX_W-1:0]   px;
    logic               hs;
    int                 rnd;
    int                 lat;
    st  = exp_state(cfg);
    lat = 4;
    // Blur adds one or two registers, never on the pattern
    if (st[3] && !cfg[CFG_TESTPAT])
      lat = (st[7] ^ st[6]) ? 6 : 5;
    for (int i = 0; i < LINE_CYC; i++) begin
      tick();
      rnd = $random(seed);
      px  = rnd[PIX_W-1:0];
      hs  = (i >= HS_LEN);
      vdata_valid_i = (i < ACTIVE);
      vsync_i       = {~vs_low, 1'b1, hs, hs & ~vs_low};  // blank never active
      vcolor_i      = px;
      if (i < ACTIVE) begin
        exp_q.push_back(exp_pixel(cfg, i, px));
        due_q.push_back(cyc + lat);
      end
    end
  endtask

  initial begin
    nVRST_Tx      = 1'b0;
    vdata_valid_i = 1'b0;
    vsync_i       = 4'hF;
    vcolor_i      = '0;
    config_i      = '0;
    use_vga_i     = 1'b0;
    repeat (2) @(negedge VCLK_Tx);
    nVRST_Tx = 1'b1;
    // Vsync low on every other line, VGA pins on the last one
    for (int k = 0; k < LINES; k++) begin
      set_config(LINE_CFG[k], k == LINES - 1);
      run_line(LINE_CFG[k], (k % 2) == 0);
    end
    for (int k = 0; k < 6; k++)
      set_config(REG_CFG[k], 1'b0);
    if (due_q.size() != 0) begin
      errors++;
      $display("%0d expected vd_o words were never checked", due_q.size());
    end
    $display("errors: %0d testbench checks, %0d bound assertions", errors,
             UUT.asserts_u.fail_cnt);
    if (errors == 0 && UUT.asserts_u.fail_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_ppu_out_asserts.sv
`default_nettype none

module tb_ppu_out_asserts import ppu_pkg::*; (
  input wire logic             VCLK_Tx,
  input wire logic             nVRST_Tx,
  input wire logic [3:0]       vsync_i,
  input wire logic             use_vga_i,
  input wire logic             en_ypbpr_i,
  input wire logic             en_rgsb_i,
  input wire logic [PIX_W-1:0] vd_i,
  input wire logic [1:0]       ncsync_i,
  input wire logic             nvsync_pin_i,
  input wire logic             nhsync_pin_i
);

  // Failures so far, read back by the testbench
  int fail_cnt = 0;

  // --------------------------------------------------------------------------
  // Reset and sync routing
  // --------------------------------------------------------------------------

  out_reset_a: assert property (@(posedge VCLK_Tx)
      !nVRST_Tx |-> (vd_i == '0 && ncsync_i == 2'b00 && !nvsync_pin_i && !nhsync_pin_i))
    else begin
      $error("outputs not cleared while in reset");
      fail_cnt++;
    end

  // Plain RGB keeps sync off green
  sog_off_a: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
      !(en_rgsb_i || en_ypbpr_i) |=> !ncsync_i[0])
    else begin
      $error("ncsync_o bit 0 active with both encodings off");
      fail_cnt++;
    end

  // The sync nibble at the output stage is the top input four clocks back
  csync_a: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
      $past(nVRST_Tx, 4) |-> ncsync_i[1] == $past(vsync_i[SY_NCSYNC], 4))
    else begin
      $error("ncsync_o bit 1 does not follow composite sync");
      fail_cnt++;
    end

  sog_on_a: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
      $past(nVRST_Tx, 4) && $past(en_rgsb_i || en_ypbpr_i)
      |-> ncsync_i[0] == $past(vsync_i[SY_NCSYNC], 4))
    else begin
      $error("ncsync_o bit 0 does not follow composite sync");
      fail_cnt++;
    end

  // Shared pins in VGA mode
  vga_pins_a: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
      $past(nVRST_Tx, 4) && $past(use_vga_i)
      |-> (nvsync_pin_i == $past(vsync_i[SY_NVSYNC], 4)
           && nhsync_pin_i == $past(vsync_i[SY_NHSYNC], 4)))
    else begin
      $error("VGA pins do not carry vsync and hsync");
      fail_cnt++;
    end

endmodule

bind ppu_out_top tb_ppu_out_asserts asserts_u (
  .VCLK_Tx(VCLK_Tx), .nVRST_Tx(nVRST_Tx), .vsync_i(vsync_i), .use_vga_i(use_vga_i),
  .en_ypbpr_i(en_ypbpr), .en_rgsb_i(en_rgsb), .vd_i(vd_o), .ncsync_i(ncsync_o),
  .nvsync_pin_i(nvsync_or_f2_o), .nhsync_pin_i(nhsync_or_f1_o)
);

`default_nettype wire

// File: testpat_gen.sv
`default_nettype none

module testpat_gen import ppu_pkg::*; (
  input  wire logic VCLK_Tx,
  input  wire logic nVRST_Tx,
  input  wire logic testpat_i,
  vdata_if.snk      vin,
  vdata_if.src      vout
);

  // Pixel position since the hsync fall, wraps every 256
  logic [7:0] px_cnt;
  logic [7:0] cnt_cur;
  // Previous hsync level of a valid pixel, idles high
  logic       hs_prev;
  logic       hs_fall;

  logic [2:0] bar_idx;
  pixel_t     bar_pix;

  // --------------------------------------------------------------------------
  // Horizontal position
  // --------------------------------------------------------------------------

  assign hs_fall = vin.valid & hs_prev & ~vin.sync[SY_NHSYNC];

  // First pixel after the fall is position 0
  assign cnt_cur = hs_fall ? 8'd0 : px_cnt;

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      px_cnt  <= 8'd0;
      hs_prev <= 1'b1;
    end else if (vin.valid) begin
      px_cnt  <= cnt_cur + 8'd1;
      hs_prev <= vin.sync[SY_NHSYNC];
    end
  end

  // --------------------------------------------------------------------------
  // Colour bars
  // --------------------------------------------------------------------------

  // Eight bars of 32 pixels each
  assign bar_idx = cnt_cur[7:5];

  // Index bits switch r, g and b fully on or off
  always_comb begin
    bar_pix.rgb.r = {COLOR_W{bar_idx[2]}};
    bar_pix.rgb.g = {COLOR_W{bar_idx[1]}};
    bar_pix.rgb.b = {COLOR_W{bar_idx[0]}};
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx)
      vout.valid <= 1'b0;
    else
      vout.valid <= vin.valid;
  end

  // Sync always passes, only the colour is replaced
  always_ff @(posedge VCLK_Tx) begin
    vout.sync <= vin.sync;
    vout.pix  <= testpat_i ? bar_pix : vin.pix;
  end

endmodule

`default_nettype wire

// File: vdata_if.sv
`default_nettype none

// Pixel bundle between two pipeline stages
// No back-pressure, sync and pix only meaningful while valid is high
interface vdata_if import ppu_pkg::*; ();

  // One-cycle strobe per pixel
  logic       valid;
  // {nVSYNC, nBLANK, nHSYNC, nCSYNC}
  logic [3:0] sync;
  pixel_t     pix;

  modport src (output valid, output sync, output pix);
  modport snk (input valid, input sync, input pix);

endinterface

`default_nettype wire

// File: vout_stage.sv
`default_nettype none

module vout_stage import ppu_pkg::*; (
  input  wire logic             VCLK_Tx,
  input  wire logic             nVRST_Tx,
  vdata_if.snk                  vin,
  input  wire logic             xchg_rb_i,
  input  wire logic             en_ypbpr_i,
  input  wire logic             en_rgsb_i,
  input  wire logic             videblur_i,
  input  wire logic             testpat_i,
  input  wire logic [1:0]       linemult_i,
  input  wire logic [1:0]       filter_i,
  input  wire logic             use_vga_i,
  output logic [PIX_W-1:0]      vd_o,
  output logic [1:0]            ncsync_o,
  output logic                  nvsync_or_f2_o,
  output logic                  nhsync_or_f1_o
);

  pixel_t pix_sw;
  // Blur delay line, tap chosen by multiplier parity
  pixel_t dly [2];
  logic   blur_en;

  // --------------------------------------------------------------------------
  // Colour output
  // --------------------------------------------------------------------------

  // Swap first and third channel, same for RGB and YPbPr words
  always_comb begin
    pix_sw = vin.pix;
    if (xchg_rb_i) begin
      pix_sw.rgb.r = vin.pix.rgb.b;
      pix_sw.rgb.b = vin.pix.rgb.r;
    end
  end

  // Pattern bars stay sharp
  assign blur_en = videblur_i & ~testpat_i;

  always_ff @(posedge VCLK_Tx) begin
    dly[0] <= pix_sw;
    dly[1] <= dly[0];
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx)
      vd_o <= '0;
    else if (blur_en)
      vd_o <= dly[^linemult_i];
    else
      vd_o <= pix_sw;
  end

  // --------------------------------------------------------------------------
  // Sync and filter pins
  // --------------------------------------------------------------------------

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      ncsync_o       <= 2'b00;
      nvsync_or_f2_o <= 1'b0;
      nhsync_or_f1_o <= 1'b0;
    end else begin
      // Bit 1 feeds the sync output
      ncsync_o[1] <= vin.sync[SY_NCSYNC];
      // Bit 0 gives sync on green/luma, held low for plain RGB
      if (en_rgsb_i || en_ypbpr_i)
        ncsync_o[0] <= vin.sync[SY_NCSYNC];
      else
        ncsync_o[0] <= 1'b0;
      // Shared pins, VGA syncs or the filter add-on select
      if (use_vga_i) begin
        nvsync_or_f2_o <= vin.sync[SY_NVSYNC];
        nhsync_or_f1_o <= vin.sync[SY_NHSYNC];
      end else begin
        nvsync_or_f2_o <= filter_i[1];
        nhsync_or_f1_o <= filter_i[0];
      end
    end
  end

endmodule

`default_nettype wire
